// File: sim/mmio_input.txt
# op address data expected, all hex
# W writes, R reads and compares, S runs one SPI loopback byte
R 80000004 00000000 00000000
W 00000004 a5a5a5a5 00000000
W 00000200 12345678 00000000
W 000003fc cafef00d 00000000
W 80000100 0badc0de 00000000
W fffffff8 76543210 00000000
R 00000004 00000000 a5a5a5a5
R 00000200 00000000 12345678
R 000003fc 00000000 cafef00d
R 80000100 00000000 0badc0de
R fffffff8 00000000 76543210
W 00000000 11111111 00000000
W 80000000 deadbeef 00000000
R 00000000 00000000 11111111
S 80000000 0000003c 0000003c
S 80000000 000000a5 000000a5
W 80000004 00000003 00000000
R 80000004 00000000 00000001
R 80000000 00000000 000000a5
R 80000040 00000000 000000ff
R 80000080 00000000 000000ff
R 800000c4 00000000 000000ff
R 80000008 00000000 000000ff

// File: mmio_top.f
+incdir+design
design/mmio_pkg.sv
design/mmio_addr_dec.sv
design/spi_regs.sv
design/spi_master.sv
design/data_ram.sv
design/mmio_top.sv
sim/mmio_clk_gen.sv
sim/mmio_assertions.sv
sim/mmio_tb.sv

// File: sim/mmio_tb.sv
`timescale 1ns/1ps

module mmio_tb import mmio_pkg::*; ();
    localparam int POLL_LIMIT = 200;                   // status reads per transfer
    localparam int RUN_LIMIT  = 20000;                 // whole run, in clocks
    localparam logic [31:0] STAT_DONE = 32'h00000001;  // busy clear, rdy set

    logic        clk;
    logic        reset;
    mmio_req_t   req;
    logic        miso;
    logic [31:0] rd;
    logic        sclk;
    logic        mosi;
    logic        cs_n;
    int          n_tests;
    int          n_fail;
    bit          test_ok;
    int          sclk_rises;

    mmio_clk_gen u_clk (.clk(clk));

    mmio_top u_dut (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .miso  (miso),
        .rd    (rd),
        .sclk  (sclk),
        .mosi  (mosi),
        .cs_n  (cs_n)
    );

    assign miso = mosi;    // loopback

    always @(posedge sclk) begin
        sclk_rises++;    // one per transferred bit
    end

    task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
        @(posedge clk);
        #1;
        req = '{addr: a, we: 1'b1, wd: d};
        @(posedge clk);    // write lands here
        #1;
        req.we = 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] a, output logic [31:0] d);
        @(posedge clk);
        #1;
        req = '{addr: a, we: 1'b0, wd: 32'h0};
        @(negedge clk);    // rd settled mid cycle
        d = rd;
    endtask

    task automatic check_rd(input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            $display("[ERROR] rd expected %08h got %08h", exp, got);
            test_ok = 0;
        end
    endtask

    task automatic spi_xfer(input logic [31:0] base, input logic [31:0] b,
                            input logic [31:0] exp);
        logic [31:0] s;
        int          polls;
        int          rises_at_start;
        bus_write(base, b);
        rises_at_start = sclk_rises;
        bus_write(base + 32'h4, 32'h4);    // start bit
        s = 32'h2;
        polls = 0;
        while (s[1] && polls < POLL_LIMIT) begin
            bus_read(base + 32'h4, s);
            polls++;
        end
        if (s[1]) begin
            $display("SPI transfer still busy after %0d status reads", polls);
            test_ok = 0;
        end else begin
            check_rd(STAT_DONE, s);
            if (sclk_rises - rises_at_start != 8) begin
                $display("[ERROR] sclk rising edges expected %08h got %08h", 8,
                         sclk_rises - rises_at_start);
                test_ok = 0;
            end
            bus_read(base, s);
            check_rd(exp, s);
        end
    endtask

    initial begin
        int n;
        for (n = 0; n < RUN_LIMIT; n++) begin
            @(posedge clk);
        end
        $display("run did not finish within %0d clocks", RUN_LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int              fd;
        int              code;
        logic [8*120-1:0] line;
        logic [63:0]     op;
        logic [31:0]     addr;
        logic [31:0]     data;
        logic [31:0]     exp;
        logic [31:0]     got;
        req     = '0;
        reset   = 1'b1;
        n_tests = 0;
        n_fail  = 0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        fd = $fopen("sim/mmio_input.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/mmio_input.txt");
            n_fail++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                op   = '0;
                code = $fgets(line, fd);
                if (code > 0) begin
                    code = $sscanf(line, "%s %h %h %h", op, addr, data, exp);
                end
                if (code == 4) begin    // comment lines fall out here
                    n_tests++;
                    test_ok = 1;
                    case (op[7:0])
                        "W": bus_write(addr, data);
                        "R": begin
                            bus_read(addr, got);
                            check_rd(exp, got);
                        end
                        "S": spi_xfer(addr, data, exp);
                        default: begin
                            $display("record %0d has an unknown op", n_tests);
                            test_ok = 0;
                        end
                    endcase
                    if (!test_ok) begin
                        n_fail++;
                    end
                    $display("test %0d %c %08h %08h %s", n_tests, op[7:0], addr, data,
                             test_ok ? "ok" : "FAILED");
                end
            end
            $fclose(fd);
        end
        $display("tests %0d, failed %0d, assertion failures %0d",
                 n_tests, n_fail, u_dut.u_assert.fail_cnt);
        if (n_fail == 0 && u_dut.u_assert.fail_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: sim/mmio_assertions.sv
`timescale 1ns/1ps
`include "mmio_defines.svh"

module mmio_assertions import mmio_pkg::*; (
    input logic      clk,
    input logic      reset,
    input mmio_req_t req,
    input mmio_req_t ram_req,
    input slot_req_t slot,
    input spi_stat_t spi_stat,
    input logic      cs_n,
    input logic      sclk
);
    localparam logic [31:0] WIN_END = `MMIO_IO_BASE + `MMIO_SLOTS * `MMIO_SLOT_BYTES;

    int   fail_cnt = 0;    // read back by the testbench
    logic in_win;

    assign in_win = (req.addr >= `MMIO_IO_BASE) && (req.addr < WIN_END);

    // one slot enabled inside the window, none outside
    slot_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(slot.en) && ((slot.en != 4'b0000) == in_win))
        else begin
            fail_cnt++;
            $error("slot enables not one-hot inside the window or set outside it");
        end

    ram_quiet_in_win: assert property (@(posedge clk) disable iff (reset)
        in_win |-> !ram_req.we)
        else begin
            fail_cnt++;
            $error("RAM write inside the I/O window");
        end

    busy_rdy_excl: assert property (@(posedge clk) disable iff (reset)
        !(spi_stat.busy && spi_stat.rdy))
        else begin
            fail_cnt++;
            $error("SPI busy and rdy both high");
        end

    // mode 0 keeps SCLK low whenever the chip select is released
    cs_tracks_busy: assert property (@(posedge clk) disable iff (reset)
        (cs_n == !spi_stat.busy) && (!cs_n || !sclk))
        else begin
            fail_cnt++;
            $error("cs_n does not follow busy or SCLK not idle low");
        end

endmodule

// decoder and engine signals are all visible at the top level
bind mmio_top mmio_assertions u_assert (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .ram_req  (ram_req),
    .slot     (slot),
    .spi_stat (spi_stat),
    .cs_n     (cs_n),
    .sclk     (sclk)
);

// File: sim/mmio_clk_gen.sv
`timescale 1ns/1ps

module mmio_clk_gen (
    output logic clk
);
    localparam int HALF_NS = 50;    // 100 ns period

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_NS clk = ~clk;
        end
    end

endmodule

// File: design/mmio_top.sv
`timescale 1ns/1ps

module mmio_top import mmio_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  mmio_req_t   req,
    input  logic        miso,
    output logic [31:0] rd,
    output logic        sclk,
    output logic        mosi,
    output logic        cs_n
);
    mmio_req_t   ram_req;
    slot_req_t   slot;
    logic [31:0] ram_rd;
    logic [31:0] spi_rd;
    spi_cmd_t    spi_cmd;
    spi_stat_t   spi_stat;

    mmio_addr_dec u_dec (
        .req     (req),
        .ram_rd  (ram_rd),
        .spi_rd  (spi_rd),
        .ram_req (ram_req),
        .slot    (slot),
        .rd      (rd)
    );

    data_ram u_ram (
        .clk (clk),
        .req (ram_req),
        .rd  (ram_rd)
    );

    // SPI controller lives in slot 0
    spi_regs u_spi_regs (
        .clk   (clk),
        .reset (reset),
        .en    (slot.en[0]),
        .we    (slot.we[0]),
        .addr  (slot.addr),
        .wd    (slot.wd),
        .stat  (spi_stat),
        .rd    (spi_rd),
        .cmd   (spi_cmd)
    );

    spi_master u_spi (
        .clk   (clk),
        .reset (reset),
        .cmd   (spi_cmd),
        .miso  (miso),
        .stat  (spi_stat),
        .sclk  (sclk),
        .mosi  (mosi),
        .cs_n  (cs_n)
    );

endmodule

// File: design/data_ram.sv
`timescale 1ns/1ps
`include "mmio_defines.svh"

module data_ram import mmio_pkg::*; (
    input  logic        clk,
    input  mmio_req_t   req,
    output logic [31:0] rd
);
    localparam int AW = $clog2(`MMIO_RAM_WORDS);

    logic [31:0]   mem [`MMIO_RAM_WORDS];
    logic [AW-1:0] idx;

    // word index, upper address bits alias
    assign idx = req.addr[AW+1:2];

    always_ff @(posedge clk) begin
        if (req.we) begin
            mem[idx] <= req.wd;
        end
    end

    assign rd = mem[idx];    // asynchronous read

endmodule

// File: design/spi_master.sv
`timescale 1ns/1ps
`include "mmio_defines.svh"

module spi_master import mmio_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  spi_cmd_t  cmd,
    input  logic      miso,
    output spi_stat_t stat,
    output logic      sclk,
    output logic      mosi,
    output logic      cs_n
);
    localparam int DIV_W = (`SPI_CLK_DIV > 1) ? $clog2(`SPI_CLK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SPI_CLK_DIV - 1);

    logic [DIV_W-1:0] div_cnt;
    logic [3:0]       edge_cnt;    // sixteen SCLK edges per byte
    logic             busy_q;
    logic             rdy_q;
    logic             sclk_q;
    logic [7:0]       rx_q;
    logic [7:0]       shreg;
    logic             miso_bit;
    logic             accept;
    logic             tick;
    logic             last_edge;

    assign accept    = cmd.start && !busy_q;          // ignored while busy
    assign tick      = busy_q && (div_cnt == DIV_LAST);
    assign last_edge = tick && sclk_q && (edge_cnt == 4'd15);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q   <= 1'b0;
            rdy_q    <= 1'b0;
            sclk_q   <= 1'b0;
            div_cnt  <= '0;
            edge_cnt <= 4'd0;
            rx_q     <= 8'h00;
        end else if (accept) begin
            busy_q   <= 1'b1;
            rdy_q    <= 1'b0;
            sclk_q   <= 1'b0;
            div_cnt  <= '0;
            edge_cnt <= 4'd0;
        end else if (tick) begin
            div_cnt  <= '0;
            edge_cnt <= edge_cnt + 4'd1;
            sclk_q   <= ~sclk_q;
            if (last_edge) begin
                busy_q <= 1'b0;
                rdy_q  <= 1'b1;
                rx_q   <= {shreg[6:0], miso_bit};    // same cycle as busy drop
            end
        end else if (busy_q) begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // mode 0 samples on the rising edge and shifts on the falling edge
    always_ff @(posedge clk) begin
        if (accept) begin
            shreg <= cmd.tx_byte;
        end else if (tick) begin
            if (!sclk_q) begin
                miso_bit <= miso;
            end else begin
                shreg <= {shreg[6:0], miso_bit};
            end
        end
    end

    assign sclk = sclk_q;
    assign mosi = busy_q & shreg[7];    // msb first, idle low
    assign cs_n = ~busy_q;

    assign stat.busy    = busy_q;
    assign stat.rdy     = rdy_q;
    assign stat.rx_byte = rx_q;

endmodule

// File: design/spi_regs.sv
`timescale 1ns/1ps
`include "mmio_defines.svh"

module spi_regs import mmio_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        en,
    input  logic        we,
    input  logic [7:0]  addr,
    input  logic [31:0] wd,
    input  spi_stat_t   stat,
    output logic [31:0] rd,
    output spi_cmd_t    cmd
);
    localparam logic [7:0] OFF_DATA = 8'h00;
    localparam logic [7:0] OFF_CTRL = 8'h04;

    logic       wr_data;
    logic       wr_ctrl;
    logic [7:0] tx_q;

    assign wr_data = en && we && (addr == OFF_DATA);
    assign wr_ctrl = en && we && (addr == OFF_CTRL);

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_q <= 8'h00;
        end else if (wr_data) begin
            tx_q <= wd[7:0];          // low byte only
        end
    end

    // bit 2 of the control word kicks off one transfer
    assign cmd.start   = wr_ctrl && wd[2];
    assign cmd.tx_byte = tx_q;

    always_comb begin
        case (addr)
            OFF_DATA: rd = {24'h0, stat.rx_byte};
            OFF_CTRL: rd = {30'h0, stat.busy, stat.rdy};
            default:  rd = `MMIO_DEFAULT_RD;
        endcase
    end

endmodule

// File: design/mmio_addr_dec.sv
`timescale 1ns/1ps
`include "mmio_defines.svh"

module mmio_addr_dec import mmio_pkg::*; (
    input  mmio_req_t   req,
    input  logic [31:0] ram_rd,
    input  logic [31:0] spi_rd,
    output mmio_req_t   ram_req,
    output slot_req_t   slot,
    output logic [31:0] rd
);
    localparam int WIN_BYTES = `MMIO_SLOTS * `MMIO_SLOT_BYTES;
    localparam int SLOT_LSB  = $clog2(`MMIO_SLOT_BYTES);

    logic [31:0] win_off;
    logic        is_io;
    logic [3:0]  slot_sel;
    rd_src_t     rd_src;

    // unsigned wrap puts everything below the base far out of range
    assign win_off = req.addr - `MMIO_IO_BASE;
    assign is_io   = (win_off < 32'(WIN_BYTES));

    assign slot_sel = 4'b0001 << win_off[SLOT_LSB +: 2];   // one-hot slot

    always_comb begin
        slot    = '0;
        ram_req = req;
        if (is_io) begin
            slot.en   = slot_sel;
            slot.we   = slot_sel & {4{req.we}};
            slot.addr = win_off[7:0];
            slot.wd   = req.wd;
            ram_req   = '0;                                 // RAM sees no write here
        end
    end

    always_comb begin
        case (slot.en)
            4'b0000: rd_src = RD_SRC_MEM;
            4'b0001: rd_src = RD_SRC_SLOT0;
            4'b0010: rd_src = RD_SRC_SLOT1;
            4'b0100: rd_src = RD_SRC_SLOT2;
            4'b1000: rd_src = RD_SRC_SLOT3;
            default: rd_src = RD_SRC_ILLEGAL;
        endcase
    end

    always_comb begin
        case (rd_src)
            RD_SRC_MEM:   rd = ram_rd;
            RD_SRC_SLOT0: rd = spi_rd;
            default:      rd = `MMIO_DEFAULT_RD;   // empty slots
        endcase
    end

endmodule

// File: design/mmio_pkg.sv
package mmio_pkg;

    // processor data bus request
    typedef struct packed {
        logic [31:0] addr;
        logic        we;
        logic [31:0] wd;
    } mmio_req_t;

    // decoded request towards the I/O slots
    typedef struct packed {
        logic [3:0]  en;     // one-hot slot enable
        logic [3:0]  we;     // per-slot write
        logic [7:0]  addr;   // offset inside the window
        logic [31:0] wd;
    } slot_req_t;

    // register block to shift engine
    typedef struct packed {
        logic       start;   // single cycle pulse
        logic [7:0] tx_byte;
    } spi_cmd_t;

    // shift engine back to register block
    typedef struct packed {
        logic       busy;
        logic       rdy;
        logic [7:0] rx_byte;
    } spi_stat_t;

    // read data source, 0 is memory and 1..4 are slots 0..3
    typedef enum logic [3:0] {
        RD_SRC_MEM     = 4'd0,
        RD_SRC_SLOT0   = 4'd1,
        RD_SRC_SLOT1   = 4'd2,
        RD_SRC_SLOT2   = 4'd3,
        RD_SRC_SLOT3   = 4'd4,
        RD_SRC_ILLEGAL = 4'hf
    } rd_src_t;

endpackage

// File: design/mmio_defines.svh
`ifndef MMIO_DEFINES_SVH
`define MMIO_DEFINES_SVH

// start of the I/O window on the data bus
`define MMIO_IO_BASE     32'h80000000

// window layout is four slots of 16 words each
`define MMIO_SLOTS       4
`define MMIO_SLOT_BYTES  64

// data RAM depth in 32-bit words, higher addresses alias
`define MMIO_RAM_WORDS   256

// system clocks per SCLK half period
`define SPI_CLK_DIV      4

// returned by empty slots and unknown register offsets
`define MMIO_DEFAULT_RD  32'h000000FF

`endif
